//--- src/core_pkg.sv
// Core-wide address constants

package core_pkg;

  // ------------------------------------------------------------------
  // Address and instruction sizes
  // ------------------------------------------------------------------

  // Width of every PC and target word
  localparam int unsigned XLEN = 32;

  // Byte-offset bits below the word index
  localparam int unsigned OFFSET = 2;

  // Sequential step between two instructions
  localparam int unsigned ILEN_BYTES = 4;

endpackage

//--- src/fetch_pkg.sv
// Front-end types and sizes

package fetch_pkg;

  // ------------------------------------------------------------------
  // Predictor sizes
  // ------------------------------------------------------------------

  // BTB index bits, 16 rows
  localparam int unsigned BTB_BITS_DEF = 4;

  // History length, also the gshare index width (64 counters)
  localparam int unsigned HLEN_DEF = 6;

  // 2-bit saturating direction counter
  typedef logic [1:0] cnt_t;

  // Weakly not taken, the counter's start value
  localparam cnt_t CNT_WNT = 2'b01;

  // ------------------------------------------------------------------
  // Interface structs
  // ------------------------------------------------------------------

  // Branch resolution coming back from execute
  typedef struct packed {
    logic                      valid;
    logic [core_pkg::XLEN-1:0] pc;
    logic [core_pkg::XLEN-1:0] target;
    logic                      taken;
    logic                      mispredict;
    // Resolved instruction is no control transfer
    logic                      del_entry;
  } res_t;

  // Request towards the instruction memory
  typedef struct packed {
    logic [core_pkg::XLEN-1:0] pc;
    logic                      pred_taken;
    // Full word, low offset bits are zero
    logic [core_pkg::XLEN-1:0] pred_target;
  } fetch_req_t;

endpackage

//--- src/btb.sv
// Direct-mapped branch target buffer

`timescale 1ns/1ps

module btb #(
  parameter int unsigned BTB_BITS = fetch_pkg::BTB_BITS_DEF
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         flush_i,
  input  logic [core_pkg::XLEN-1:0]                    curr_pc_i,
  input  logic                                         res_valid_i,
  input  logic                                         del_entry_i,
  input  logic [core_pkg::XLEN-1:0]                    res_pc_i,
  input  logic [core_pkg::XLEN-1:0]                    res_target_i,
  output logic                                         hit_o,
  output logic [core_pkg::XLEN-core_pkg::OFFSET-1:0]   target_o
);

  import core_pkg::*;

  localparam int unsigned Rows   = 1 << BTB_BITS;
  localparam int unsigned TagLen = XLEN - BTB_BITS - OFFSET;

  // One row: valid flag, upper PC bits, word-aligned target
  typedef struct packed {
    logic                   valid;
    logic [TagLen-1:0]      tag;
    logic [XLEN-OFFSET-1:0] target;
  } entry_t;

  entry_t              rows_q [Rows];
  logic [BTB_BITS-1:0] idx_w;
  logic [BTB_BITS-1:0] idx_r;
  logic [TagLen-1:0]   tag_w;
  logic [TagLen-1:0]   tag_r;

  // ------------------------------------------------------------------
  // Update from resolution
  // ------------------------------------------------------------------
  assign idx_w = res_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign tag_w = res_pc_i[XLEN-1:BTB_BITS+OFFSET];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Rows; i++) begin
        rows_q[i] <= '0;
      end
    end else if (flush_i) begin
      // Whole table emptied in one cycle
      for (int i = 0; i < Rows; i++) begin
        rows_q[i] <= '0;
      end
    end else if (res_valid_i) begin
      if (del_entry_i) begin
        // Not a control transfer, drop the row
        rows_q[idx_w] <= '0;
      end else begin
        rows_q[idx_w].valid  <= 1'b1;
        rows_q[idx_w].tag    <= tag_w;
        rows_q[idx_w].target <= res_target_i[XLEN-1:OFFSET];
      end
    end
  end

  // ------------------------------------------------------------------
  // Lookup, same cycle
  // ------------------------------------------------------------------
  assign idx_r = curr_pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign tag_r = curr_pc_i[XLEN-1:BTB_BITS+OFFSET];

  assign hit_o    = rows_q[idx_r].valid & (rows_q[idx_r].tag == tag_r);
  assign target_o = rows_q[idx_r].target;

  // A delete request must come with a known strobe from execute
  a_del_strobe_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    del_entry_i |-> !$isunknown(res_valid_i)
  );

endmodule

//--- src/gshare.sv
// Gshare direction predictor

`timescale 1ns/1ps

module gshare #(
  parameter int unsigned HLEN = fetch_pkg::HLEN_DEF
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic [core_pkg::XLEN-1:0] curr_pc_i,
  input  logic                      res_valid_i,
  input  logic [core_pkg::XLEN-1:0] res_pc_i,
  input  logic                      res_taken_i,
  input  logic                      res_skip_i,
  output logic                      taken_o
);

  import core_pkg::*;
  import fetch_pkg::*;

  localparam int unsigned Rows = 1 << HLEN;

  logic [HLEN-1:0] hist_q;
  logic [HLEN-1:0] hist_d;
  cnt_t            cnt_q [Rows];
  cnt_t            cnt_w;
  cnt_t            cnt_next;
  logic [HLEN-1:0] idx_r;
  logic [HLEN-1:0] idx_w;
  logic            train;

  // Only resolved control transfers train the predictor
  assign train = res_valid_i & ~res_skip_i;

  // ------------------------------------------------------------------
  // Index hashing
  // ------------------------------------------------------------------
  // Training index uses history before this update
  assign idx_w = res_pc_i[HLEN+OFFSET-1:OFFSET] ^ hist_q;
  assign idx_r = curr_pc_i[HLEN+OFFSET-1:OFFSET] ^ hist_q;

  // ------------------------------------------------------------------
  // Saturating counter step
  // ------------------------------------------------------------------
  assign cnt_w = cnt_q[idx_w];

  always_comb begin
    cnt_next = cnt_w;
    if (res_taken_i) begin
      // Stop at strongly taken
      if (cnt_w != 2'b11) begin
        cnt_next = cnt_w + 2'b01;
      end
    end else begin
      // Stop at strongly not taken
      if (cnt_w != 2'b00) begin
        cnt_next = cnt_w - 2'b01;
      end
    end
  end

  // Newest outcome enters at bit 0, oldest falls off the top
  assign hist_d = HLEN'({hist_q, res_taken_i});

  // ------------------------------------------------------------------
  // Global history register
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q <= '0;
    end else if (flush_i) begin
      hist_q <= '0;
    end else if (train) begin
      hist_q <= hist_d;
    end
  end

  // ------------------------------------------------------------------
  // Counter table
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Rows; i++) begin
        cnt_q[i] <= CNT_WNT;
      end
    end else if (flush_i) begin
      // Flush returns every counter to its start value
      for (int i = 0; i < Rows; i++) begin
        cnt_q[i] <= CNT_WNT;
      end
    end else if (train) begin
      cnt_q[idx_w] <= cnt_next;
    end
  end

  // Upper counter bit is the direction
  assign taken_o = cnt_q[idx_r][1];

  // A resolution brings a known skip bit and outcome into the history
  a_hist_known_in: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    res_valid_i |-> !$isunknown({res_skip_i, res_taken_i})
  );

endmodule

//--- src/pc_gen.sv
// PC register stage

`timescale 1ns/1ps

module pc_gen (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      stall_i,
  input  logic                      redirect_i,
  input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                      pred_taken_i,
  input  logic [core_pkg::XLEN-1:0] pred_target_i,
  output logic [core_pkg::XLEN-1:0] curr_pc_o
);

  import core_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;
  logic [XLEN-1:0] seq_pc;
  logic [XLEN-1:0] redir_pc;

  // ------------------------------------------------------------------
  // Next PC candidates
  // ------------------------------------------------------------------
  assign seq_pc = pc_q + XLEN'(ILEN_BYTES);

  // All instructions are word aligned
  assign redir_pc = {redirect_pc_i[XLEN-1:OFFSET], {OFFSET{1'b0}}};

  // Priority: redirect, then prediction, then sequential
  always_comb begin
    if (redirect_i) begin
      pc_d = redir_pc;
    end else if (pred_taken_i) begin
      pc_d = pred_target_i;
    end else begin
      pc_d = seq_pc;
    end
  end

  // ------------------------------------------------------------------
  // PC register
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= '0;
    end else if (redirect_i || !stall_i) begin
      // Redirect is taken even while stalled
      pc_q <= pc_d;
    end
  end

  assign curr_pc_o = pc_q;

  // PC stays aligned across every source
  a_pc_aligned: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    curr_pc_o[OFFSET-1:0] == '0
  );

endmodule

//--- src/fetch_stage.sv
// Prediction and fetch request stage

`timescale 1ns/1ps

module fetch_stage (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       flush_i,
  input  logic                                       stall_i,
  input  logic                                       redirect_i,
  input  logic [core_pkg::XLEN-1:0]                  curr_pc_i,
  input  logic                                       btb_hit_i,
  input  logic [core_pkg::XLEN-core_pkg::OFFSET-1:0] btb_target_i,
  input  logic                                       bp_taken_i,
  output logic                                       pred_taken_o,
  output logic [core_pkg::XLEN-1:0]                  pred_target_o,
  output logic                                       req_valid_o,
  output fetch_pkg::fetch_req_t                      req_o
);

  import core_pkg::*;
  import fetch_pkg::*;

  logic       valid_q;
  fetch_req_t req_q;

  // ------------------------------------------------------------------
  // Prediction
  // ------------------------------------------------------------------
  // Taken needs a known target and a taken direction
  assign pred_taken_o  = btb_hit_i & bp_taken_i;
  assign pred_target_o = {btb_target_i, {OFFSET{1'b0}}};

  // ------------------------------------------------------------------
  // Request register
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      req_q   <= '0;
    end else begin
      if (redirect_i || flush_i) begin
        // In-flight PC is wrong-path, kill it
        valid_q <= 1'b0;
      end else if (!stall_i) begin
        valid_q <= 1'b1;
      end
      if (!stall_i) begin
        req_q.pc          <= curr_pc_i;
        req_q.pred_taken  <= pred_taken_o;
        req_q.pred_target <= pred_target_o;
      end
    end
  end

  assign req_valid_o = valid_q;
  assign req_o       = req_q;

endmodule

//--- src/fetch_predict.sv
// Branch prediction front end

`timescale 1ns/1ps

module fetch_predict (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  stall_i,
  input  fetch_pkg::res_t       res_i,
  output logic                  req_valid_o,
  output fetch_pkg::fetch_req_t req_o
);

  import core_pkg::*;
  import fetch_pkg::*;

  logic [XLEN-1:0]        curr_pc;
  logic                   btb_hit;
  logic [XLEN-OFFSET-1:0] btb_target;
  logic                   bp_taken;
  logic                   pred_taken;
  logic [XLEN-1:0]        pred_target;
  logic                   redirect;
  logic                   btb_upd;

  // ------------------------------------------------------------------
  // Resolution decode
  // ------------------------------------------------------------------
  // Mispredicted resolution restarts fetch
  assign redirect = res_i.valid & res_i.mispredict;

  // BTB sees deletions and taken branches only
  assign btb_upd = res_i.valid & (res_i.del_entry | res_i.taken);

  // ------------------------------------------------------------------
  // Stages and predictors
  // ------------------------------------------------------------------
  pc_gen u_pc_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .stall_i       (stall_i),
    .redirect_i    (redirect),
    .redirect_pc_i (res_i.target),
    .pred_taken_i  (pred_taken),
    .pred_target_i (pred_target),
    .curr_pc_o     (curr_pc)
  );

  btb #(
    .BTB_BITS (BTB_BITS_DEF)
  ) u_btb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .curr_pc_i    (curr_pc),
    .res_valid_i  (btb_upd),
    .del_entry_i  (res_i.del_entry),
    .res_pc_i     (res_i.pc),
    .res_target_i (res_i.target),
    .hit_o        (btb_hit),
    .target_o     (btb_target)
  );

  gshare #(
    .HLEN (HLEN_DEF)
  ) u_gshare (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .curr_pc_i   (curr_pc),
    .res_valid_i (res_i.valid),
    .res_pc_i    (res_i.pc),
    .res_taken_i (res_i.taken),
    .res_skip_i  (res_i.del_entry),
    .taken_o     (bp_taken)
  );

  fetch_stage u_fetch_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .stall_i       (stall_i),
    .redirect_i    (redirect),
    .curr_pc_i     (curr_pc),
    .btb_hit_i     (btb_hit),
    .btb_target_i  (btb_target),
    .bp_taken_i    (bp_taken),
    .pred_taken_o  (pred_taken),
    .pred_target_o (pred_target),
    .req_valid_o   (req_valid_o),
    .req_o         (req_o)
  );

endmodule

//--- testbench/tb_clock.sv
// Testbench clock source

`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk_o
);

  // Free-running clock, starts low so the first rising edge is at half a period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule

//--- testbench/tb_fetch_predict.sv
// Fetch predictor testbench

`timescale 1ns/1ps

module tb_fetch_predict;

  import core_pkg::*;
  import fetch_pkg::*;

  localparam int unsigned BtbRows = 1 << BTB_BITS_DEF;
  localparam int unsigned CntRows = 1 << HLEN_DEF;
  localparam int unsigned TagW    = XLEN - BTB_BITS_DEF - OFFSET;
  localparam int unsigned Cycles  = 3000;
  localparam int unsigned WaitMax = 200;
  // Directed branch and target lie away from the pool PCs
  localparam logic [XLEN-1:0] BrPc  = 32'h0000_0080;
  localparam logic [XLEN-1:0] BrTgt = 32'h0000_0200;

  logic       clk;
  logic       rst_n;
  logic       flush;
  logic       stall;
  res_t       res;
  logic       req_valid;
  fetch_req_t req;

  // ------------------------------------------------------------------
  // Reference model state
  // ------------------------------------------------------------------
  logic                   m_bv   [BtbRows];
  logic [TagW-1:0]        m_btag [BtbRows];
  logic [XLEN-OFFSET-1:0] m_btgt [BtbRows];
  cnt_t                   m_cnt  [CntRows];
  logic [HLEN_DEF-1:0]    m_hist;
  logic [XLEN-1:0]        m_pc;
  logic                   m_valid;
  fetch_req_t             m_req;

  logic [31:0] rng;
  int unsigned check_errs;
  int unsigned timeout_errs;

  tb_clock u_tb_clock (
    .clk_o (clk)
  );

  fetch_predict u_fetch_predict (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .flush_i     (flush),
    .stall_i     (stall),
    .res_i       (res),
    .req_valid_o (req_valid),
    .req_o       (req)
  );

  // ------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Eight branch PCs
  // 0x10 and 0x50 share a BTB row with different tags
  function automatic logic [XLEN-1:0] pool_pc(input logic [2:0] sel);
    case (sel)
      3'd0:    return 32'h0000_0010;
      3'd1:    return 32'h0000_0024;
      3'd2:    return 32'h0000_0038;
      3'd3:    return 32'h0000_0050;
      3'd4:    return 32'h0000_0064;
      3'd5:    return 32'h0000_008c;
      3'd6:    return 32'h0000_00a0;
      default: return 32'h0000_00d0;
    endcase
  endfunction

  function automatic res_t make_res(input logic vld, input logic [XLEN-1:0] pc,
                                    input logic [XLEN-1:0] tgt, input logic tkn,
                                    input logic mis, input logic del);
    res_t r;
    r            = '0;
    r.valid      = vld;
    r.pc         = pc;
    r.target     = tgt;
    r.taken      = tkn;
    r.mispredict = mis;
    r.del_entry  = del;
    return r;
  endfunction

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------
  task automatic model_reset();
    for (int i = 0; i < BtbRows; i++) begin
      m_bv[i]   = 1'b0;
      m_btag[i] = '0;
      m_btgt[i] = '0;
    end
    for (int i = 0; i < CntRows; i++) begin
      m_cnt[i] = 2'b01;
    end
    m_hist  = '0;
    m_pc    = '0;
    m_valid = 1'b0;
    m_req   = '0;
  endtask

  // Advances the model by one clock edge with the given inputs
  task automatic model_step(input logic fl, input logic st, input res_t r);
    logic [BTB_BITS_DEF-1:0] bi;
    logic [BTB_BITS_DEF-1:0] wi;
    logic [HLEN_DEF-1:0]     gi;
    logic [HLEN_DEF-1:0]     ti;
    logic                    hit;
    logic                    ptaken;
    logic [XLEN-1:0]         ptgt;
    logic                    redir;
    // Lookups on the current PC before any update
    bi     = m_pc[BTB_BITS_DEF+OFFSET-1:OFFSET];
    hit    = m_bv[bi] && (m_btag[bi] == m_pc[XLEN-1:BTB_BITS_DEF+OFFSET]);
    gi     = m_pc[HLEN_DEF+OFFSET-1:OFFSET] ^ m_hist;
    ptaken = hit && m_cnt[gi][1];
    ptgt   = {m_btgt[bi], {OFFSET{1'b0}}};
    redir  = r.valid && r.mispredict;
    // Request register takes the old PC
    if (!st) begin
      m_req.pc          = m_pc;
      m_req.pred_taken  = ptaken;
      m_req.pred_target = ptgt;
    end
    if (redir || fl) begin
      m_valid = 1'b0;
    end else if (!st) begin
      m_valid = 1'b1;
    end
    // Redirect moves the PC even under stall
    if (redir) begin
      m_pc = {r.target[XLEN-1:OFFSET], {OFFSET{1'b0}}};
    end else if (!st) begin
      m_pc = ptaken ? ptgt : m_pc + XLEN'(ILEN_BYTES);
    end
    // Predictor tables
    if (fl) begin
      for (int i = 0; i < BtbRows; i++) begin
        m_bv[i]   = 1'b0;
        m_btag[i] = '0;
        m_btgt[i] = '0;
      end
      for (int i = 0; i < CntRows; i++) begin
        m_cnt[i] = 2'b01;
      end
      m_hist = '0;
    end else if (r.valid) begin
      wi = r.pc[BTB_BITS_DEF+OFFSET-1:OFFSET];
      if (r.del_entry) begin
        m_bv[wi]   = 1'b0;
        m_btag[wi] = '0;
        m_btgt[wi] = '0;
      end else begin
        if (r.taken) begin
          m_bv[wi]   = 1'b1;
          m_btag[wi] = r.pc[XLEN-1:BTB_BITS_DEF+OFFSET];
          m_btgt[wi] = r.target[XLEN-1:OFFSET];
        end
        // Counter index uses the history before the shift
        ti = r.pc[HLEN_DEF+OFFSET-1:OFFSET] ^ m_hist;
        if (r.taken && m_cnt[ti] != 2'b11) begin
          m_cnt[ti] = m_cnt[ti] + 2'b01;
        end else if (!r.taken && m_cnt[ti] != 2'b00) begin
          m_cnt[ti] = m_cnt[ti] - 2'b01;
        end
        m_hist = {m_hist[HLEN_DEF-2:0], r.taken};
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Checks and cycle stepping
  // ------------------------------------------------------------------
  task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      check_errs++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // Valid flag and the whole held request against the model
  task automatic check_outputs();
    compare_word("req_valid_o", XLEN'(req_valid), XLEN'(m_valid));
    compare_word("req_o.pc", req.pc, m_req.pc);
    compare_word("req_o.pred_taken", XLEN'(req.pred_taken), XLEN'(m_req.pred_taken));
    compare_word("req_o.pred_target", req.pred_target, m_req.pred_target);
  endtask

  // Drive just after an edge and sample half a nanosecond after the next one
  task automatic step_cycle(input logic fl, input logic st, input res_t r);
    flush = fl;
    stall = st;
    res   = r;
    model_step(fl, st, r);
    @(posedge clk);
    #0.5;
    check_outputs();
  endtask

  // Idles until a valid request shows up (at pc when match_pc is set)
  task automatic wait_for_req(input logic match_pc, input logic [XLEN-1:0] pc,
                              output logic found);
    int unsigned n;
    found = 1'b0;
    n     = 0;
    while (!found && n < WaitMax) begin
      if (req_valid && (!match_pc || req.pc == pc)) begin
        found = 1'b1;
      end else begin
        step_cycle(1'b0, 1'b0, '0);
        n++;
      end
    end
    if (!found) begin
      timeout_errs++;
      $display("Timeout: no valid fetch request at PC 0x%h within %0d cycles", pc, WaitMax);
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    logic        found;
    logic [31:0] v;
    res_t        r;
    rng          = 32'd97500;
    check_errs   = 0;
    timeout_errs = 0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    stall        = 1'b0;
    res          = '0;
    model_reset();
    repeat (5) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    // No request in the first cycle out of reset
    check_outputs();
    wait_for_req(1'b0, '0, found);

    // Eight taken resolutions leave the history all ones and the counter strong
    for (int k = 0; k < 8; k++) begin
      step_cycle(1'b0, 1'b0, make_res(1'b1, BrPc, BrTgt, 1'b1, 1'b0, 1'b0));
    end
    // Mispredict from a neighbour PC sends fetch to the trained branch
    step_cycle(1'b0, 1'b0, make_res(1'b1, BrPc + 32'd4, BrPc, 1'b1, 1'b1, 1'b0));
    wait_for_req(1'b1, BrPc, found);
    if (found) begin
      compare_word("req_o.pred_taken", XLEN'(req.pred_taken), XLEN'(1'b1));
    end

    // Entry deletion with a redirect back to the same branch
    step_cycle(1'b0, 1'b0, make_res(1'b1, BrPc, BrPc, 1'b0, 1'b1, 1'b1));
    wait_for_req(1'b1, BrPc, found);
    if (found) begin
      compare_word("req_o.pred_taken", XLEN'(req.pred_taken), XLEN'(1'b0));
    end
    step_cycle(1'b1, 1'b0, '0);

    // Random traffic with rare flushes and short stalls
    for (int c = 0; c < Cycles; c++) begin
      rng = xorshift(rng);
      v   = rng;
      r   = '0;
      if (v[1:0] == 2'b00) begin
        rng = xorshift(rng);
        // pc_gen and the BTB align the random low target bits
        r = make_res(1'b1, pool_pc(v[4:2]), rng & 32'h0000_00ff, v[5],
                     v[7:6] == 2'b00, v[10:8] == 3'b000);
      end
      step_cycle(v[16:11] == 6'd0, v[19:17] == 3'd0, r);
    end

    $display("Check errors: %0d, timeouts: %0d", check_errs, timeout_errs);
    if (check_errs == 0 && timeout_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- tb.f
src/core_pkg.sv
src/fetch_pkg.sv
src/btb.sv
src/gshare.sv
src/pc_gen.sv
src/fetch_stage.sv
src/fetch_predict.sv
testbench/tb_clock.sv
testbench/tb_fetch_predict.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_fetch_predict
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
